/* verilog/bf_pkg.sv */
package bf_pkg;

    // Array and sample sizes
    localparam int NUM_CHANNELS = 8;
    localparam int CH_WIDTH     = 3;
    localparam int DATA_WIDTH   = 16;
    localparam int SUM_WIDTH    = DATA_WIDTH + $clog2(NUM_CHANNELS);

    // Capture depth, one sample set per clock
    localparam int MAX_DELAY   = 64;
    localparam int DELAY_WIDTH = 6;

    // Focal geometry in path units
    localparam int POS_WIDTH   = 16;
    localparam int PATH_WIDTH  = POS_WIDTH + 1;
    localparam int DELAY_SHIFT = 2;
    localparam int ELEM_PITCH  = 16;

    // Register map
    localparam int CFG_ADDR_WIDTH = 4;
    localparam int MASK_ADDR      = 8;

    // Sequencer states
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE    = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_CAPTURE = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_SUM     = 2'd2;
    localparam logic [STATE_WIDTH-1:0] ST_FINISH  = 2'd3;

    // Counter value on the last finish cycle, lets the read pipe and adder drain
    localparam int FINISH_LAST = 1;

    typedef struct packed {
        logic [POS_WIDTH-1:0] x_f;
        logic [POS_WIDTH-1:0] z_f;
    } focus_t;

    typedef struct packed {
        logic                      we;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [POS_WIDTH-1:0]      wdata;
    } cfg_wr_t;

endpackage

/* verilog/bf_cfg_regs.sv */
`timescale 1ns/1ns

module bf_cfg_regs
    import bf_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  cfg_wr_t                                cfg,
    output logic [NUM_CHANNELS-1:0][POS_WIDTH-1:0] elem_x,
    output logic [NUM_CHANNELS-1:0]                chan_mask
);

    logic pos_hit;
    logic mask_hit;

    // Low addresses map to element positions
    assign pos_hit  = cfg.addr < CFG_ADDR_WIDTH'(NUM_CHANNELS);
    assign mask_hit = cfg.addr == CFG_ADDR_WIDTH'(MASK_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Evenly spaced array, all elements on
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                elem_x[i] <= POS_WIDTH'(i * ELEM_PITCH);
            end
            chan_mask <= '1;
        end else if (cfg.we) begin
            if (pos_hit) begin
                elem_x[cfg.addr[CH_WIDTH-1:0]] <= cfg.wdata;
            end
            if (mask_hit) begin
                chan_mask <= cfg.wdata[NUM_CHANNELS-1:0];
            end
        end
    end

endmodule

/* verilog/bf_delay_calc.sv */
`timescale 1ns/1ns

module bf_delay_calc
    import bf_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start_accept,
    input  focus_t                                 focus,
    input  logic [NUM_CHANNELS-1:0][POS_WIDTH-1:0] elem_x,
    input  logic [CH_WIDTH-1:0]                    chan_sel,
    output logic [DELAY_WIDTH-1:0]                 delay
);

    focus_t                focus_q;
    logic [POS_WIDTH-1:0]  elem_pos;
    logic [POS_WIDTH-1:0]  lateral;
    logic [PATH_WIDTH-1:0] path;
    logic [PATH_WIDTH-1:0] path_shifted;

    // Hold the focal point for the whole run
    always_ff @(posedge clk) begin
        if (reset) begin
            focus_q <= '0;
        end else if (start_accept) begin
            focus_q <= focus;
        end
    end

    assign elem_pos = elem_x[chan_sel];

    // |x_f - elem_x| without going signed
    assign lateral = (focus_q.x_f >= elem_pos) ? focus_q.x_f - elem_pos
                                               : elem_pos - focus_q.x_f;

    assign path         = {1'b0, lateral} + {1'b0, focus_q.z_f};
    assign path_shifted = path >> DELAY_SHIFT;

    // Clamp to the deepest captured set
    assign delay = (path_shifted > PATH_WIDTH'(MAX_DELAY - 1)) ? DELAY_WIDTH'(MAX_DELAY - 1)
                                                               : path_shifted[DELAY_WIDTH-1:0];

endmodule

/* verilog/bf_sample_buffer.sv */
`timescale 1ns/1ns

module bf_sample_buffer
    import bf_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    capture_en,
    input  logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] rf_data,
    output logic                                    full,
    input  logic [CH_WIDTH-1:0]                     rd_chan,
    input  logic [DELAY_WIDTH-1:0]                  rd_delay,
    output logic signed [DATA_WIDTH-1:0]            rd_sample
);

    logic [DATA_WIDTH-1:0]  mem [NUM_CHANNELS][MAX_DELAY];
    logic [DELAY_WIDTH-1:0] wr_idx;
    logic                   wr_last;

    assign wr_last = wr_idx == DELAY_WIDTH'(MAX_DELAY - 1);

    // Write index and the full pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            full   <= 1'b0;
        end else begin
            full <= capture_en && wr_last;
            if (capture_en) begin
                // Wraps back to 0 after the last set
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // One sample set per clock, all channels side by side
    always_ff @(posedge clk) begin
        if (capture_en) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                mem[ch][wr_idx] <= rf_data[ch];
            end
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rd_sample <= mem[rd_chan][rd_delay];
    end

endmodule

/* verilog/bf_sequencer.sv */
`timescale 1ns/1ns

module bf_sequencer
    import bf_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    full,
    input  logic [NUM_CHANNELS-1:0] chan_mask,
    output logic                    start_accept,
    output logic                    capture_en,
    output logic [CH_WIDTH-1:0]     chan_sel,
    output logic                    sum_first,
    output logic                    sum_en,
    output logic                    valid
);

    logic [STATE_WIDTH-1:0] state;
    logic                   last_chan;
    logic                   in_sum;

    // Start only counts in idle
    assign start_accept = (state == ST_IDLE) && start;

    // Index 0 goes in on the accepting edge itself
    assign capture_en = start_accept || ((state == ST_CAPTURE) && !full);

    assign in_sum    = state == ST_SUM;
    assign last_chan = chan_sel == CH_WIDTH'(NUM_CHANNELS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            chan_sel  <= '0;
            sum_first <= 1'b0;
            sum_en    <= 1'b0;
            valid     <= 1'b0;
        end else begin
            valid <= 1'b0;

            // Marks line up with the registered buffer read
            sum_first <= in_sum && (chan_sel == '0);
            sum_en    <= in_sum && chan_mask[chan_sel];

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_CAPTURE;
                        chan_sel <= '0;
                    end
                end
                ST_CAPTURE: begin
                    if (full) begin
                        state    <= ST_SUM;
                        chan_sel <= '0;
                    end
                end
                ST_SUM: begin
                    // One read per channel
                    if (last_chan) begin
                        state    <= ST_FINISH;
                        chan_sel <= '0;
                    end else begin
                        chan_sel <= chan_sel + 1'b1;
                    end
                end
                ST_FINISH: begin
                    // Counter reused to wait out the last add
                    if (chan_sel == CH_WIDTH'(FINISH_LAST)) begin
                        state    <= ST_IDLE;
                        chan_sel <= '0;
                        valid    <= 1'b1;
                    end else begin
                        chan_sel <= chan_sel + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/bf_serial_adder.sv */
`timescale 1ns/1ns

module bf_serial_adder
    import bf_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sum_first,
    input  logic                        sum_en,
    input  logic signed [DATA_WIDTH-1:0] sample,
    input  logic                        valid_in,
    output logic signed [SUM_WIDTH-1:0] sum_out
);

    logic signed [SUM_WIDTH-1:0] sample_ext;
    logic signed [SUM_WIDTH-1:0] acc;
    logic signed [SUM_WIDTH-1:0] result_q;

    assign sample_ext = SUM_WIDTH'(sample);

    always_ff @(posedge clk) begin
        if (sum_first) begin
            // Masked first channel starts from zero
            acc <= sum_en ? sample_ext : '0;
        end else if (sum_en) begin
            acc <= acc + sample_ext;
        end
    end

    // Keep the last result once the pulse is over
    always_ff @(posedge clk) begin
        if (reset) begin
            result_q <= '0;
        end else if (valid_in) begin
            result_q <= acc;
        end
    end

    // New result shows up together with the valid pulse
    assign sum_out = valid_in ? acc : result_q;

endmodule

/* verilog/bf_top.sv */
`timescale 1ns/1ns

module bf_top
    import bf_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  focus_t                                  focus,
    input  cfg_wr_t                                 cfg,
    input  logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] rf_data,
    output logic signed [SUM_WIDTH-1:0]             beamformed_output,
    output logic                                    valid
);

    logic [NUM_CHANNELS-1:0][POS_WIDTH-1:0] elem_x;
    logic [NUM_CHANNELS-1:0]                chan_mask;
    logic                                   start_accept;
    logic                                   capture_en;
    logic                                   full;
    logic [CH_WIDTH-1:0]                    chan_sel;
    logic [DELAY_WIDTH-1:0]                 delay;
    logic signed [DATA_WIDTH-1:0]           rd_sample;
    logic                                   sum_first;
    logic                                   sum_en;

    bf_cfg_regs cfg_regs_i (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .elem_x    (elem_x),
        .chan_mask (chan_mask)
    );

    bf_delay_calc delay_calc_i (
        .clk          (clk),
        .reset        (reset),
        .start_accept (start_accept),
        .focus        (focus),
        .elem_x       (elem_x),
        .chan_sel     (chan_sel),
        .delay        (delay)
    );

    bf_sample_buffer sample_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .capture_en (capture_en),
        .rf_data    (rf_data),
        .full       (full),
        .rd_chan    (chan_sel),
        .rd_delay   (delay),
        .rd_sample  (rd_sample)
    );

    bf_sequencer sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .full         (full),
        .chan_mask    (chan_mask),
        .start_accept (start_accept),
        .capture_en   (capture_en),
        .chan_sel     (chan_sel),
        .sum_first    (sum_first),
        .sum_en       (sum_en),
        .valid        (valid)
    );

    // Valid also latches the result inside the adder
    bf_serial_adder serial_adder_i (
        .clk       (clk),
        .reset     (reset),
        .sum_first (sum_first),
        .sum_en    (sum_en),
        .sample    (rd_sample),
        .valid_in  (valid),
        .sum_out   (beamformed_output)
    );

endmodule

/* dv/bf_props.sv */
`timescale 1ns/1ns

module bf_props (
    input logic clk,
    input logic reset,
    input logic valid,
    input logic capture_en,
    input logic sum_en
);

    // Result strobe is a single cycle
    valid_one_cycle: assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
        else $error("valid stayed high on two consecutive cycles");

    valid_reset_low: assert property (@(posedge clk) reset |=> !valid)
        else $error("valid high while reset is applied");

    // Capture and summation phases never overlap
    capture_sum_apart: assert property (@(posedge clk) disable iff (reset)
        !(capture_en && sum_en))
        else $error("capture_en and sum_en high in the same cycle");

endmodule

bind bf_sequencer bf_props props_i (
    .clk        (clk),
    .reset      (reset),
    .valid      (valid),
    .capture_en (capture_en),
    .sum_en     (sum_en)
);

/* dv/bf_tb.sv */
`timescale 1ns/1ns

module bf_tb
    import bf_pkg::*;
();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 5;
    localparam int NUM_ROWS     = 10;
    localparam int RESULT_EDGES = MAX_DELAY + NUM_CHANNELS + 2;
    localparam int RESTART_IDX  = 20;
    localparam int WATCHDOG_NS  = PERIOD * (RESET_CYCLES + IDLE_CYCLES
                                  + NUM_ROWS * (MAX_DELAY + NUM_CHANNELS + 10));

    typedef struct packed {
        logic [POS_WIDTH-1:0]    x_f;
        logic [POS_WIDTH-1:0]    z_f;
        logic                    pos_we;
        logic [CH_WIDTH-1:0]     pos_ch;
        logic [POS_WIDTH-1:0]    pos_val;
        logic [NUM_CHANNELS-1:0] mask;
        logic                    restart;
    } row_t;

    logic                                    clk;
    logic                                    reset;
    logic                                    start;
    focus_t                                  focus;
    cfg_wr_t                                 cfg;
    logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] rf_data;
    logic signed [SUM_WIDTH-1:0]             beamformed_output;
    logic                                    valid;

    // x_f, z_f, pos_we, pos_ch, pos_val, mask, restart
    row_t table_rows [NUM_ROWS] = '{
        '{16'd56,    16'd40,    1'b0, 3'd0, 16'd0,      8'hff, 1'b0},
        '{16'd0,     16'd0,     1'b0, 3'd0, 16'd0,      8'hff, 1'b0},
        '{16'd100,   16'd120,   1'b0, 3'd0, 16'd0,      8'hff, 1'b1},
        '{16'd180,   16'd20,    1'b1, 3'd2, 16'd200,    8'hff, 1'b0},
        '{16'd30,    16'd60,    1'b1, 3'd5, 16'd5,      8'hff, 1'b0},
        '{16'd60,    16'd80,    1'b0, 3'd0, 16'd0,      8'ha6, 1'b0},
        '{16'd10,    16'd30,    1'b0, 3'd0, 16'd0,      8'h7e, 1'b1},
        '{16'd900,   16'd200,   1'b0, 3'd0, 16'd0,      8'hff, 1'b0},
        '{16'd240,   16'd100,   1'b0, 3'd0, 16'd0,      8'hff, 1'b0},
        '{16'hffff,  16'hffff,  1'b1, 3'd7, 16'hfff0,   8'hff, 1'b0}
    };

    logic [31:0]                  lfsr;
    logic signed [DATA_WIDTH-1:0] samples [NUM_CHANNELS][MAX_DELAY];
    logic [POS_WIDTH-1:0]         ref_pos [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0]      ref_mask;
    logic signed [SUM_WIDTH-1:0]  last_result;
    int                           errors;
    int                           checks;

    bf_top dut_i (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .focus             (focus),
        .cfg               (cfg),
        .rf_data           (rf_data),
        .beamformed_output (beamformed_output),
        .valid             (valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Result: FAILED");
        $finish;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Indexes past the capture depth are filler only
    task automatic drive_set(input int idx);
        logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] set;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            set[ch] = DATA_WIDTH'(take_bits(DATA_WIDTH));
            if (idx < MAX_DELAY) begin
                samples[ch][idx] = set[ch];
            end
        end
        rf_data <= set;
    endtask

    function automatic logic signed [SUM_WIDTH-1:0] expected_sum(input row_t row);
        logic signed [SUM_WIDTH-1:0] sum;
        int lateral;
        int dly;
        sum = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            lateral = int'(row.x_f) - int'(ref_pos[ch]);
            if (lateral < 0) begin
                lateral = -lateral;
            end
            dly = (lateral + int'(row.z_f)) >> DELAY_SHIFT;
            if (dly > MAX_DELAY - 1) begin
                dly = MAX_DELAY - 1;
            end
            if (ref_mask[ch]) begin
                sum = sum + SUM_WIDTH'(samples[ch][dly]);
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic run_row(input int r);
        row_t                        row;
        logic signed [SUM_WIDTH-1:0] exp_sum;
        int                          edges;
        row = table_rows[r];
        if (row.pos_we) begin
            @(posedge clk);
            cfg <= '{we: 1'b1, addr: CFG_ADDR_WIDTH'(row.pos_ch), wdata: row.pos_val};
            ref_pos[row.pos_ch] = row.pos_val;
        end
        @(posedge clk);
        cfg <= '{we: 1'b1, addr: CFG_ADDR_WIDTH'(MASK_ADDR), wdata: POS_WIDTH'(row.mask)};
        ref_mask = row.mask;
        @(posedge clk);
        cfg   <= '0;
        start <= 1'b1;
        focus <= '{x_f: row.x_f, z_f: row.z_f};
        drive_set(0);
        // Loop edge k-1 after the accepting edge stores set k
        for (int k = 1; k < MAX_DELAY; k++) begin
            @(posedge clk);
            start <= row.restart && (k == RESTART_IDX);
            // Focus must already be latched
            focus <= '1;
            drive_set(k);
            // No early pulse while capturing
            @(negedge clk);
            check_value("valid", valid, 0);
        end
        exp_sum = expected_sum(row);
        edges   = MAX_DELAY - 2;
        do begin
            @(posedge clk);
            edges++;
            // Extra start lands in the sum phase
            start <= row.restart && (edges == MAX_DELAY + 2);
            drive_set(MAX_DELAY);
            @(negedge clk);
            if (!valid) begin
                check_value("beamformed_output", beamformed_output, last_result);
            end
        end while (!valid && edges < RESULT_EDGES + 10);
        if (!valid) begin
            errors++;
            $display("Row %0d: no valid pulse within %0d edges of start", r, edges);
        end else begin
            check_value("valid_edges", edges, RESULT_EDGES);
            check_value("beamformed_output", beamformed_output, exp_sum);
            @(negedge clk);
            check_value("valid", valid, 0);
            check_value("beamformed_output", beamformed_output, exp_sum);
        end
        last_result = exp_sum;
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        lfsr        = 32'haf74_5fb3;
        last_result = '0;
        reset       = 1'b1;
        start       = 1'b0;
        focus       = '0;
        cfg         = '0;
        rf_data     = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            ref_pos[ch] = POS_WIDTH'(ch * ELEM_PITCH);
        end
        ref_mask = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // Quiet output until the first start
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("valid", valid, 0);
            check_value("beamformed_output", beamformed_output, 0);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/bf_pkg.sv
verilog/bf_cfg_regs.sv
verilog/bf_delay_calc.sv
verilog/bf_sample_buffer.sv
verilog/bf_sequencer.sv
verilog/bf_serial_adder.sv
verilog/bf_top.sv
dv/bf_props.sv
dv/bf_tb.sv
